/* tb.f */
rtl/lc3b_types.sv
rtl/if_datapath.sv
rtl/regfile.sv
rtl/id_datapath.sv
rtl/ex_datapath.sv
rtl/buffer.sv
rtl/mem_datapath.sv
rtl/cpu_datapath.sv
verif/cpu_assertions.sv
verif/cpu_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

/* verif/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

    import lc3b_types::*;

    localparam int prog_max = 1024;

    logic     clk;
    logic     rst;
    logic     resp_a;
    logic     resp_b;
    lc3b_word rdata_a;
    lc3b_word rdata_b;
    logic     read_a;
    logic     read_b;
    logic     write_b;
    lc3b_word address_a;
    lc3b_word address_b;
    lc3b_word wdata_b;

    lc3b_word prog [prog_max];
    int       prog_len;
    int       last_w1;
    int       last_w2;
    int       max_lat;
    int       errs;
    lc3b_word data_mem [lc3b_word];
    lc3b_word exp_addr[$];
    lc3b_word exp_data[$];

    cpu_datapath u_dut (
        .clk(clk), .rst(rst),
        .resp_a(resp_a), .rdata_a(rdata_a), .read_a(read_a), .address_a(address_a),
        .resp_b(resp_b), .rdata_b(rdata_b), .read_b(read_b), .write_b(write_b),
        .address_b(address_b), .wdata_b(wdata_b)
    );

    cpu_checker u_checker (
        .clk(clk), .rst(rst), .read_a(read_a), .address_a(address_a),
        .read_b(read_b), .write_b(write_b), .resp_b(resp_b),
        .address_b(address_b), .wdata_b(wdata_b)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic lc3b_word fetch_word(input lc3b_word addr);
        int idx;
        idx = int'(addr[15:1]);
        return (idx < prog_len) ? prog[idx] : 16'h0000;
    endfunction

    // Unwritten data words read as address XOR 5A5A
    function automatic lc3b_word read_data(input lc3b_word addr);
        return data_mem.exists(addr) ? data_mem[addr] : (addr ^ 16'h5A5A);
    endfunction

    initial begin : port_a_model
        int lat;
        int cnt;
        forever begin
            @(posedge clk);
            #1;
            resp_a = 1'b0;
            if (!rst && read_a) begin
                lat = 1 + int'($urandom % max_lat);
                cnt = 1;
                while (cnt < lat && !rst) begin
                    @(posedge clk);
                    #1;
                    cnt++;
                end
                if (!rst) begin
                    rdata_a = fetch_word(address_a);
                    resp_a  = 1'b1;
                end
            end
        end
    end

    initial begin : port_b_model
        int lat;
        int cnt;
        forever begin
            @(posedge clk);
            #1;
            resp_b = 1'b0;
            if (!rst && (read_b || write_b)) begin
                lat = 1 + int'($urandom % max_lat);
                cnt = 1;
                while (cnt < lat && !rst) begin
                    @(posedge clk);
                    #1;
                    cnt++;
                end
                if (!rst) begin
                    if (write_b) begin
                        data_mem[address_b] = wdata_b;
                    end else begin
                        rdata_b = read_data(address_b);
                    end
                    resp_b = 1'b1;
                end
            end
        end
    end

    // ISA model that runs the program in order and lists the stores
    function automatic void compute_expected();
        lc3b_word   r [8];
        lc3b_word   mem [lc3b_word];
        lc3b_word   ins;
        lc3b_word   b;
        lc3b_word   a;
        lc3b_opcode op;
        exp_addr.delete();
        exp_data.delete();
        for (int k = 0; k < 8; k++) begin
            r[k] = 16'h0000;
        end
        for (int i = 0; i < prog_len; i++) begin
            ins = prog[i];
            op  = ins[15:12];
            b   = ins[5] ? {{11{ins[4]}}, ins[4:0]} : r[ins[2:0]];
            a   = r[ins[8:6]] + {{9{ins[5]}}, ins[5:0], 1'b0};
            case (op)
                op_add: r[ins[11:9]] = r[ins[8:6]] + b;
                op_and: r[ins[11:9]] = r[ins[8:6]] & b;
                op_not: r[ins[11:9]] = ~r[ins[8:6]];
                op_ldr: r[ins[11:9]] = mem.exists(a) ? mem[a] : (a ^ 16'h5A5A);
                op_str: begin
                    mem[a] = r[ins[11:9]];
                    exp_addr.push_back(a);
                    exp_data.push_back(r[ins[11:9]]);
                end
                default: ;
            endcase
        end
    endfunction

    function automatic lc3b_word alu_op(lc3b_opcode op, int dr, int sr, int imm_form, int b);
        if (imm_form != 0) begin
            return {op, dr[2:0], sr[2:0], 1'b1, b[4:0]};
        end
        return {op, dr[2:0], sr[2:0], 3'b000, b[2:0]};
    endfunction

    function automatic lc3b_word mem_op(lc3b_opcode op, int r, int base, int off);
        return {op, r[2:0], base[2:0], off[5:0]};
    endfunction

    function automatic lc3b_word not_op(int dr, int sr);
        return {op_not, dr[2:0], sr[2:0], 6'h3f};
    endfunction

    function automatic bit too_close(int s);
        return (s >= 0) && ((s == last_w1) || (s == last_w2));
    endfunction

    // Pads with no-ops so no source was written by the two previous instructions
    task automatic append(input lc3b_word ins);
        int s1;
        int s2;
        int d;
        lc3b_opcode op;
        op = ins[15:12];
        s1 = -1;
        s2 = -1;
        d  = -1;
        if (op == op_add || op == op_and) begin
            s1 = ins[8:6];
            s2 = ins[5] ? -1 : int'(ins[2:0]);
            d  = ins[11:9];
        end else if (op == op_not || op == op_ldr) begin
            s1 = ins[8:6];
            d  = ins[11:9];
        end else if (op == op_str) begin
            s1 = ins[8:6];
            s2 = ins[11:9];
        end
        while (too_close(s1) || too_close(s2)) begin
            prog[prog_len] = 16'h0000;
            prog_len = prog_len + 1;
            last_w2 = last_w1;
            last_w1 = -1;
        end
        prog[prog_len] = ins;
        prog_len = prog_len + 1;
        last_w2 = last_w1;
        last_w1 = d;
    endtask

    // Mix 0 gives ALU ops only, 1 adds loads and stores and 2 adds unsupported opcodes
    function automatic lc3b_word random_instr(int mix);
        int sel;
        int unsup [11] = '{0, 2, 3, 4, 8, 10, 11, 12, 13, 14, 15};
        sel = int'($urandom % ((mix == 0) ? 3 : (mix == 1) ? 5 : 7));
        case (sel)
            0: return alu_op(op_add, $urandom % 8, $urandom % 8, $urandom % 2, $urandom);
            1: return alu_op(op_and, $urandom % 8, $urandom % 8, $urandom % 2, $urandom);
            2: return not_op($urandom % 8, $urandom % 8);
            3: return mem_op(op_ldr, $urandom % 8, $urandom % 8, $urandom);
            4: return mem_op(op_str, $urandom % 8, $urandom % 8, $urandom);
            default: return {4'(unsup[$urandom % 11]), 12'($urandom)};
        endcase
    endfunction

    task automatic new_program();
        @(posedge clk);
        #1;
        rst      = 1'b1;
        prog_len = 0;
        last_w1  = -1;
        last_w2  = -1;
        data_mem.delete();
    endtask

    task automatic run_test(input string name, input int lat);
        for (int k = 0; k < 8; k++) begin
            append(mem_op(op_str, k, 0, k));
        end
        max_lat = lat;
        compute_expected();
        u_checker.start_test(name);
        for (int i = 0; i < exp_addr.size(); i++) begin
            u_checker.add_expected(exp_addr[i], exp_data[i]);
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        u_checker.check_reset_state();
        u_checker.wait_stores();
    endtask

    initial begin
        void'($urandom(5));
        rst = 1'b1;
        resp_a = 1'b0;
        resp_b = 1'b0;
        rdata_a = 16'h0000;
        rdata_b = 16'h0000;
        max_lat = 1;
        prog_len = 0;

        new_program();
        run_test("reset_state", 1);

        new_program();
        for (int i = 0; i < 40; i++) begin
            append(random_instr(0));
        end
        run_test("alu_program", 1);

        new_program();
        append(mem_op(op_ldr, 1, 0, 3));
        append(mem_op(op_ldr, 2, 0, -4));
        append(not_op(3, 1));
        append(mem_op(op_str, 3, 0, 10));
        append(mem_op(op_ldr, 4, 0, 10));
        append(alu_op(op_add, 5, 4, 1, 1));
        append(alu_op(op_and, 6, 2, 0, 1));
        append(mem_op(op_str, 2, 1, -1));
        append(mem_op(op_ldr, 7, 1, -1));
        run_test("load_store", 2);

        new_program();
        for (int i = 0; i < 200; i++) begin
            append(random_instr(1));
        end
        run_test("random_mix", 4);

        new_program();
        for (int i = 0; i < 80; i++) begin
            append(random_instr(2));
        end
        run_test("unsupported_ops", 4);

        errs = u_checker.summarize(u_dut.u_asrt.fail_count);
        if (errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_top

/* verif/cpu_checker.sv */
`timescale 1ns/10ps

module cpu_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 read_a,
    input  lc3b_types::lc3b_word address_a,
    input  logic                 read_b,
    input  logic                 write_b,
    input  logic                 resp_b,
    input  lc3b_types::lc3b_word address_b,
    input  lc3b_types::lc3b_word wdata_b
);

    import lc3b_types::*;

    localparam int store_timeout = 20000;
    localparam int fetch_timeout = 10;
    localparam int drain_cycles  = 40;

    lc3b_word exp_addr_q[$];
    lc3b_word exp_data_q[$];
    lc3b_word ea;
    lc3b_word ed;
    string    test_name = "none";
    int       test_errors = 0;
    int       total_errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       stores_seen = 0;
    logic     rst_seen = 1'b0;

    // Sampled on the falling edge, away from the drive point
    always @(negedge clk) begin
        if (rst && rst_seen && (read_b || write_b)) begin
            $display("test %s: port B request active during reset", test_name);
            test_errors++;
        end
        if (!rst && write_b && resp_b) begin
            if (exp_addr_q.size() == 0) begin
                $display("test %s: unexpected store of %h to %h", test_name, wdata_b, address_b);
                test_errors++;
            end else begin
                ea = exp_addr_q.pop_front();
                ed = exp_data_q.pop_front();
                if (ea !== address_b || ed !== wdata_b) begin
                    $display("** Error %s store %0d: expected %h @ %h, actual %h @ %h",
                             test_name, stores_seen, ed, ea, wdata_b, address_b);
                    test_errors++;
                end
                stores_seen++;
            end
        end
        rst_seen = rst;
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        stores_seen = 0;
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic add_expected(input lc3b_word addr, input lc3b_word data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // Called right after reset is released
    task automatic check_reset_state();
        int cnt;
        cnt = 0;
        while (!read_a && cnt < fetch_timeout) begin
            @(negedge clk);
            if (read_b || write_b) begin
                $display("test %s: port B request right after reset", test_name);
                test_errors++;
            end
            cnt++;
        end
        if (!read_a) begin
            $display("test %s: no instruction fetch started after reset", test_name);
            test_errors++;
        end else if (address_a !== 16'h0000) begin
            $display("** Error %s first fetch: expected %h, actual %h",
                     test_name, 16'h0000, address_a);
            test_errors++;
        end
    endtask

    task automatic wait_stores();
        int cnt;
        cnt = 0;
        while (exp_addr_q.size() > 0 && cnt < store_timeout) begin
            @(negedge clk);
            cnt++;
        end
        if (exp_addr_q.size() > 0) begin
            $display("test %s: timed out with %0d expected stores never seen",
                     test_name, exp_addr_q.size());
            test_errors++;
        end
        // Extra stores would show up here
        cnt = 0;
        while (cnt < drain_cycles) begin
            @(negedge clk);
            cnt++;
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d stores checked, %0d errors", test_name,
                 (test_errors == 0) ? "pass" : "fail", stores_seen, test_errors);
    endtask

    function automatic int summarize(input int assert_fails);
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, total_errors, assert_fails);
        return total_errors + assert_fails;
    endfunction

endmodule : cpu_checker

/* verif/cpu_assertions.sv */
`timescale 1ns/10ps

module cpu_assertions (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 read_a,
    input  logic                 resp_a,
    input  lc3b_types::lc3b_word address_a,
    input  logic                 read_b,
    input  logic                 write_b,
    input  logic                 resp_b,
    input  lc3b_types::lc3b_word address_b,
    input  lc3b_types::lc3b_word wdata_b
);

    int fail_count = 0;

    // Port B carries one kind of request at a time
    one_request_b: assert property (@(posedge clk) disable iff (rst)
        !(read_b && write_b))
        else begin
            fail_count++;
            $error("read_b and write_b high together");
        end

    hold_request_a: assert property (@(posedge clk) disable iff (rst)
        (read_a && !resp_a) |=> (read_a && $stable(address_a)))
        else begin
            fail_count++;
            $error("port A request changed before resp_a");
        end

    hold_request_b: assert property (@(posedge clk) disable iff (rst)
        ((read_b || write_b) && !resp_b) |=>
        ($stable(read_b) && $stable(write_b) && $stable(address_b) && $stable(wdata_b)))
        else begin
            fail_count++;
            $error("port B request changed before resp_b");
        end

    // First reset cycle still shows the old register contents
    quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !(read_a || read_b || write_b))
        else begin
            fail_count++;
            $error("memory request active during reset");
        end

endmodule : cpu_assertions

bind cpu_datapath cpu_assertions u_asrt (
    .clk(clk),
    .rst(rst),
    .read_a(read_a),
    .resp_a(resp_a),
    .address_a(address_a),
    .read_b(read_b),
    .write_b(write_b),
    .resp_b(resp_b),
    .address_b(address_b),
    .wdata_b(wdata_b)
);

/* rtl/cpu_datapath.sv */
`timescale 1ns/10ps

module cpu_datapath (
    input  logic                 clk,
    input  logic                 rst,

    /* Port A */
    input  logic                 resp_a,
    input  lc3b_types::lc3b_word rdata_a,
    output logic                 read_a,
    output lc3b_types::lc3b_word address_a,

    /* Port B */
    input  logic                 resp_b,
    input  lc3b_types::lc3b_word rdata_b,
    output logic                 read_b,
    output logic                 write_b,
    output lc3b_types::lc3b_word address_b,
    output lc3b_types::lc3b_word wdata_b
);

    import lc3b_types::*;

    logic stall;
    logic fetch_pending;

    // IF
    lc3b_word if_instruction;
    lc3b_word if_id_inst;

    // ID
    lc3b_control_word id_ctrl;
    lc3b_reg          id_dest;
    lc3b_word         id_sr1_data;
    lc3b_word         id_sr2_data;
    lc3b_word         id_imm;

    lc3b_control_word id_ex_ctrl;
    lc3b_reg          id_ex_dest;
    lc3b_word         id_ex_sr1_data;
    lc3b_word         id_ex_imm;
    lc3b_word         id_ex_sr2_data;

    // EX
    lc3b_word         ex_alu;
    lc3b_word         ex_addr;

    lc3b_control_word ex_mem_ctrl;
    lc3b_reg          ex_mem_dest;
    lc3b_word         ex_mem_alu;
    lc3b_word         ex_mem_addr;
    lc3b_word         ex_mem_store;

    // MEM and WB
    lc3b_word         mem_result;

    lc3b_control_word mem_wb_ctrl;
    lc3b_reg          mem_wb_dest;
    lc3b_word         mem_wb_data;
    logic             wb_reg_write;

    assign wb_reg_write = mem_wb_ctrl[cw_reg_write];

    if_datapath if_dp (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .resp_a(resp_a),
        .rdata_a(rdata_a),
        .read_a(read_a),
        .address_a(address_a),
        .fetch_pending(fetch_pending),
        .pc(),
        .instruction(if_instruction)
    );

    // Instruction rides in the alu field
    buffer if_id_buf (
        .clk(clk),
        .rst(rst),
        .load(~stall),
        .ctrl_in('0),
        .dest_in('0),
        .alu_in(if_instruction),
        .addr_in('0),
        .store_in('0),
        .ctrl_out(),
        .dest_out(),
        .alu_out(if_id_inst),
        .addr_out(),
        .store_out()
    );

    id_datapath id_dp (
        .clk(clk),
        .rst(rst),
        .inst(if_id_inst),
        .ctrl(id_ctrl),
        .dest(id_dest),
        .sr1(),
        .sr2(),
        .sr1_out(id_sr1_data),
        .sr2_out(id_sr2_data),
        .imm(id_imm),
        .wb_reg_write(wb_reg_write),
        .wb_dest(mem_wb_dest),
        .wb_data(mem_wb_data)
    );

    buffer id_ex_buf (
        .clk(clk),
        .rst(rst),
        .load(~stall),
        .ctrl_in(id_ctrl),
        .dest_in(id_dest),
        .alu_in(id_sr1_data),
        .addr_in(id_imm),
        .store_in(id_sr2_data),
        .ctrl_out(id_ex_ctrl),
        .dest_out(id_ex_dest),
        .alu_out(id_ex_sr1_data),
        .addr_out(id_ex_imm),
        .store_out(id_ex_sr2_data)
    );

    ex_datapath ex_dp (
        .ctrl(id_ex_ctrl),
        .sr1_data(id_ex_sr1_data),
        .sr2_data(id_ex_sr2_data),
        .imm(id_ex_imm),
        .alu_out(ex_alu),
        .addr_out(ex_addr)
    );

    buffer ex_mem_buf (
        .clk(clk),
        .rst(rst),
        .load(~stall),
        .ctrl_in(id_ex_ctrl),
        .dest_in(id_ex_dest),
        .alu_in(ex_alu),
        .addr_in(ex_addr),
        .store_in(id_ex_sr2_data),
        .ctrl_out(ex_mem_ctrl),
        .dest_out(ex_mem_dest),
        .alu_out(ex_mem_alu),
        .addr_out(ex_mem_addr),
        .store_out(ex_mem_store)
    );

    mem_datapath mem_dp (
        .clk(clk),
        .rst(rst),
        .ctrl_in(ex_mem_ctrl),
        .addr_in(ex_mem_addr),
        .store_in(ex_mem_store),
        .alu_in(ex_mem_alu),
        .fetch_pending(fetch_pending),
        .resp_b(resp_b),
        .rdata_b(rdata_b),
        .read_b(read_b),
        .write_b(write_b),
        .address_b(address_b),
        .wdata_b(wdata_b),
        .stall(stall),
        .result(mem_result)
    );

    // Selected result goes straight back to the register file
    buffer mem_wb_buf (
        .clk(clk),
        .rst(rst),
        .load(~stall),
        .ctrl_in(ex_mem_ctrl),
        .dest_in(ex_mem_dest),
        .alu_in(mem_result),
        .addr_in('0),
        .store_in('0),
        .ctrl_out(mem_wb_ctrl),
        .dest_out(mem_wb_dest),
        .alu_out(mem_wb_data),
        .addr_out(),
        .store_out()
    );

endmodule : cpu_datapath

/* rtl/mem_datapath.sv */
`timescale 1ns/10ps

module mem_datapath (
    input  logic                         clk,
    input  logic                         rst,

    input  lc3b_types::lc3b_control_word ctrl_in,
    input  lc3b_types::lc3b_word         addr_in,
    input  lc3b_types::lc3b_word         store_in,
    input  lc3b_types::lc3b_word         alu_in,
    input  logic                         fetch_pending,

    /* Port B */
    input  logic                         resp_b,
    input  lc3b_types::lc3b_word         rdata_b,
    output logic                         read_b,
    output logic                         write_b,
    output lc3b_types::lc3b_word         address_b,
    output lc3b_types::lc3b_word         wdata_b,

    output logic                         stall,
    output lc3b_types::lc3b_word         result
);

    import lc3b_types::*;

    logic     done_b;
    logic     mem_wait;
    lc3b_word hold_b;
    lc3b_word load_data;

    // Request drops once answered, until the pipeline moves on
    assign read_b    = ctrl_in[cw_mem_read] & ~done_b;
    assign write_b   = ctrl_in[cw_mem_write] & ~done_b;
    assign address_b = addr_in;
    assign wdata_b   = store_in;

    assign mem_wait = (read_b | write_b) & ~resp_b;
    assign stall    = mem_wait | fetch_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            done_b <= 1'b0;
        end else if (!stall) begin
            done_b <= 1'b0;
        end else if (resp_b && (read_b || write_b)) begin
            done_b <= 1'b1;
        end
    end

    // Load data parked while IF is still waiting
    always_ff @(posedge clk) begin
        if (resp_b && read_b) begin
            hold_b <= rdata_b;
        end
    end

    assign load_data = done_b ? hold_b : rdata_b;
    assign result    = ctrl_in[cw_mem_read] ? load_data : alu_in;

endmodule : mem_datapath

/* rtl/buffer.sv */
`timescale 1ns/10ps

module buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load,

    input  lc3b_types::lc3b_control_word ctrl_in,
    input  lc3b_types::lc3b_reg          dest_in,
    input  lc3b_types::lc3b_word         alu_in,
    input  lc3b_types::lc3b_word         addr_in,
    input  lc3b_types::lc3b_word         store_in,

    output lc3b_types::lc3b_control_word ctrl_out,
    output lc3b_types::lc3b_reg          dest_out,
    output lc3b_types::lc3b_word         alu_out,
    output lc3b_types::lc3b_word         addr_out,
    output lc3b_types::lc3b_word         store_out
);

    // A cleared control word is a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_out <= '0;
        end else if (load) begin
            ctrl_out <= ctrl_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dest_out  <= dest_in;
            alu_out   <= alu_in;
            addr_out  <= addr_in;
            store_out <= store_in;
        end
    end

endmodule : buffer

/* rtl/ex_datapath.sv */
`timescale 1ns/10ps

module ex_datapath (
    input  lc3b_types::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word         sr1_data,
    input  lc3b_types::lc3b_word         sr2_data,
    input  lc3b_types::lc3b_word         imm,
    output lc3b_types::lc3b_word         alu_out,
    output lc3b_types::lc3b_word         addr_out
);

    import lc3b_types::*;

    lc3b_aluop aluop;
    lc3b_word  operand_b;

    assign aluop     = ctrl[cw_aluop_hi:cw_aluop_lo];
    assign operand_b = ctrl[cw_use_imm] ? imm : sr2_data;

    always_comb begin
        case (aluop)
            alu_add:  alu_out = sr1_data + operand_b;
            alu_and:  alu_out = sr1_data & operand_b;
            alu_not:  alu_out = ~sr1_data;
            alu_pass: alu_out = sr1_data;
        endcase
    end

    // Base register plus scaled offset for LDR and STR
    assign addr_out = sr1_data + imm;

endmodule : ex_datapath

/* rtl/id_datapath.sv */
`timescale 1ns/10ps

module id_datapath (
    input  logic                         clk,
    input  logic                         rst,
    input  lc3b_types::lc3b_word         inst,

    output lc3b_types::lc3b_control_word ctrl,
    output lc3b_types::lc3b_reg          dest,
    output lc3b_types::lc3b_reg          sr1,
    output lc3b_types::lc3b_reg          sr2,
    output lc3b_types::lc3b_word         sr1_out,
    output lc3b_types::lc3b_word         sr2_out,
    output lc3b_types::lc3b_word         imm,

    /* From WB */
    input  logic                         wb_reg_write,
    input  lc3b_types::lc3b_reg          wb_dest,
    input  lc3b_types::lc3b_word         wb_data
);

    import lc3b_types::*;

    lc3b_opcode opcode;
    logic       is_mem;

    assign opcode = inst[15:12];
    assign is_mem = (opcode == op_ldr) || (opcode == op_str);

    always_comb begin
        ctrl = '0;
        case (opcode)
            op_add: begin
                ctrl[cw_aluop_hi:cw_aluop_lo] = alu_add;
                ctrl[cw_use_imm]              = inst[5];
                ctrl[cw_reg_write]            = 1'b1;
            end
            op_and: begin
                ctrl[cw_aluop_hi:cw_aluop_lo] = alu_and;
                ctrl[cw_use_imm]              = inst[5];
                ctrl[cw_reg_write]            = 1'b1;
            end
            op_not: begin
                ctrl[cw_aluop_hi:cw_aluop_lo] = alu_not;
                ctrl[cw_reg_write]            = 1'b1;
            end
            op_ldr: begin
                ctrl[cw_aluop_hi:cw_aluop_lo] = alu_pass;
                ctrl[cw_mem_read]             = 1'b1;
                ctrl[cw_reg_write]            = 1'b1;
            end
            op_str: begin
                ctrl[cw_aluop_hi:cw_aluop_lo] = alu_pass;
                ctrl[cw_mem_write]            = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // STR reads its source register through the second port
    assign dest = inst[11:9];
    assign sr1  = inst[8:6];
    assign sr2  = (opcode == op_str) ? inst[11:9] : inst[2:0];

    // offset6 is a word offset, imm5 is used as is
    assign imm = is_mem ? {{9{inst[5]}}, inst[5:0], 1'b0} : {{11{inst[4]}}, inst[4:0]};

    regfile rf (
        .clk(clk),
        .rst(rst),
        .reg_write(wb_reg_write),
        .dest(wb_dest),
        .wdata(wb_data),
        .sr1(sr1),
        .sr2(sr2),
        .sr1_out(sr1_out),
        .sr2_out(sr2_out)
    );

endmodule : id_datapath

/* rtl/regfile.sv */
`timescale 1ns/10ps

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reg_write,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word wdata,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word sr1_out,
    output lc3b_types::lc3b_word sr2_out
);

    lc3b_types::lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (reg_write) begin
            regs[dest] <= wdata;
        end
    end

    // Same-cycle write is visible on the read ports
    assign sr1_out = (reg_write && (dest == sr1)) ? wdata : regs[sr1];
    assign sr2_out = (reg_write && (dest == sr2)) ? wdata : regs[sr2];

endmodule : regfile

/* rtl/if_datapath.sv */
`timescale 1ns/10ps

module if_datapath (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,

    /* Port A */
    input  logic                 resp_a,
    input  lc3b_types::lc3b_word rdata_a,
    output logic                 read_a,
    output lc3b_types::lc3b_word address_a,

    output logic                 fetch_pending,
    output lc3b_types::lc3b_word pc,
    output lc3b_types::lc3b_word instruction
);

    logic     fetch_en;
    logic     done_a;
    lc3b_types::lc3b_word pc_reg;
    lc3b_types::lc3b_word hold_a;

    // Fetching starts one cycle after reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_reg   <= 16'h0000;
            fetch_en <= 1'b0;
            done_a   <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (!stall && fetch_en) begin
                pc_reg <= pc_reg + 16'd2;
            end
            if (!stall) begin
                done_a <= 1'b0;
            end else if (resp_a && read_a) begin
                done_a <= 1'b1;
            end
        end
    end

    // Word kept while the rest of the pipeline waits
    always_ff @(posedge clk) begin
        if (resp_a) begin
            hold_a <= rdata_a;
        end
    end

    assign read_a        = fetch_en & ~done_a;
    assign address_a     = pc_reg;
    assign pc            = pc_reg;
    assign fetch_pending = read_a & ~resp_a;

    // No-op until the first fetch is under way
    assign instruction = !fetch_en ? 16'h0000 : (done_a ? hold_a : rdata_a);

endmodule : if_datapath

/* rtl/lc3b_types.sv */
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [3:0]  lc3b_opcode;
    typedef logic [1:0]  lc3b_aluop;

    // From MSB down: aluop, use_imm, mem_read, mem_write, reg_write
    typedef logic [5:0]  lc3b_control_word;

    // Supported opcodes, everything else decodes to a no-op
    localparam lc3b_opcode op_add = 4'b0001;
    localparam lc3b_opcode op_and = 4'b0101;
    localparam lc3b_opcode op_not = 4'b1001;
    localparam lc3b_opcode op_ldr = 4'b0110;
    localparam lc3b_opcode op_str = 4'b0111;

    // ALU operations
    localparam lc3b_aluop alu_add  = 2'd0;
    localparam lc3b_aluop alu_and  = 2'd1;
    localparam lc3b_aluop alu_not  = 2'd2;
    localparam lc3b_aluop alu_pass = 2'd3;

    // Control word bit positions
    localparam int cw_aluop_hi  = 5;
    localparam int cw_aluop_lo  = 4;
    localparam int cw_use_imm   = 3;
    localparam int cw_mem_read  = 2;
    localparam int cw_mem_write = 1;
    localparam int cw_reg_write = 0;

endpackage : lc3b_types
